//--- flist.f
rtl/cpu_pkg.sv
rtl/decode_pkg.sv
rtl/fetch_buffer.sv
rtl/decode_branch.sv
rtl/decoder.sv
rtl/decode_queue.sv
rtl/decode_stage.sv
testbench/decode_stage_checker.sv
testbench/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode_stage
FLIST     := flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- testbench/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

import cpu_pkg::*;
import decode_pkg::*;

localparam int QUEUE_DEPTH = 4;
localparam int N_INSTR     = 63; // all instructions sent over the run

localparam int K_ADDU      = 0;
localparam int K_SLT       = 1;
localparam int K_SLLV      = 2;
localparam int K_MULT      = 3;
localparam int K_MADD      = 4;
localparam int K_CLZ       = 5;
localparam int K_ADDIU     = 6;
localparam int K_ANDI      = 7;
localparam int K_LUI       = 8;
localparam int K_LW        = 9;
localparam int K_SB        = 10;
localparam int K_LL        = 11;
localparam int K_BEQ       = 12;
localparam int K_BGEZAL    = 13;
localparam int K_J         = 14;
localparam int K_JAL       = 15;
localparam int K_JR        = 16;
localparam int K_JALR      = 17;
localparam int K_BAD_OPC   = 18;
localparam int K_BAD_FUNCT = 19;
localparam int K_OPC_47    = 20;

typedef struct {
	uint32_t   pc;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	op_t       op;
	fu_t       fu;
	cf_t       cf;
	logic      use_imm;
	logic      imm_signed;
	uint32_t   imm;
	uint32_t   target;
} exp_t;

logic      clk;
logic      rst_n;
logic      in_valid;
logic      in_ready;
uint32_t   in_pc;
uint32_t   in_instr;
logic      out_valid;
logic      out_ready;
uint32_t   out_pc;
reg_addr_t out_rs1;
reg_addr_t out_rs2;
reg_addr_t out_rd;
op_t       out_op;
fu_t       out_fu;
cf_t       out_cf;
logic      out_use_imm;
logic      out_imm_signed;
uint32_t   out_imm;
uint32_t   out_target;

exp_t  exp_q[$];
string cur_test;
int    value_errors;
int    other_errors;
int    held;
logic  pend_in;
logic  pend_out;
logic  random_ready;

decode_stage #(
	.QUEUE_DEPTH (QUEUE_DEPTH),
	.RESET_PC    (32'h0)
) dut_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.in_valid       (in_valid),
	.in_ready       (in_ready),
	.in_pc          (in_pc),
	.in_instr       (in_instr),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.out_pc         (out_pc),
	.out_rs1        (out_rs1),
	.out_rs2        (out_rs2),
	.out_rd         (out_rd),
	.out_op         (out_op),
	.out_fu         (out_fu),
	.out_cf         (out_cf),
	.out_use_imm    (out_use_imm),
	.out_imm_signed (out_imm_signed),
	.out_imm        (out_imm),
	.out_target     (out_target)
);

always #50 clk = ~clk;

task automatic compare_reg(string field, reg_addr_t exp, reg_addr_t act);
	if (exp !== act) begin
		$display("error %s %s: expected %0d actual %0d", cur_test, field, exp, act);
		value_errors++;
	end
endtask

task automatic compare_op(op_t exp, op_t act);
	if (exp !== act) begin
		$display("error %s op: expected %s actual %s", cur_test, exp.name(), act.name());
		value_errors++;
	end
endtask

task automatic compare_fu(fu_t exp, fu_t act);
	if (exp !== act) begin
		$display("error %s fu: expected %s actual %s", cur_test, exp.name(), act.name());
		value_errors++;
	end
endtask

task automatic compare_cf(cf_t exp, cf_t act);
	if (exp !== act) begin
		$display("error %s cf: expected %s actual %s", cur_test, exp.name(), act.name());
		value_errors++;
	end
endtask

task automatic compare_bit(string field, logic exp, logic act);
	if (exp !== act) begin
		$display("error %s %s: expected %b actual %b", cur_test, field, exp, act);
		value_errors++;
	end
endtask

task automatic compare_word(string field, uint32_t exp, uint32_t act);
	if (exp !== act) begin
		$display("error %s %s: expected %h actual %h", cur_test, field, exp, act);
		value_errors++;
	end
endtask

function automatic uint32_t encode(int kind, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [15:0] imm16, logic [25:0] idx);
	case (kind)
		K_ADDU:      return {6'h00, rs, rt, rd, 5'd0, 6'h21};
		K_SLT:       return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
		K_SLLV:      return {6'h00, rs, rt, rd, 5'd0, 6'h04};
		K_MULT:      return {6'h00, rs, rt, rd, 5'd0, 6'h18};
		K_MADD:      return {6'h1c, rs, rt, rd, 5'd0, 6'h00};
		K_CLZ:       return {6'h1c, rs, rt, rd, 5'd0, 6'h20};
		K_ADDIU:     return {6'h09, rs, rt, imm16};
		K_ANDI:      return {6'h0c, rs, rt, imm16};
		K_LUI:       return {6'h0f, rs, rt, imm16};
		K_LW:        return {6'h23, rs, rt, imm16};
		K_SB:        return {6'h28, rs, rt, imm16};
		K_LL:        return {6'h30, rs, rt, imm16};
		K_BEQ:       return {6'h04, rs, rt, imm16};
		K_BGEZAL:    return {6'h01, rs, 5'h11, imm16};
		K_J:         return {6'h02, idx};
		K_JAL:       return {6'h03, idx};
		K_JR:        return {6'h00, 5'd31, 5'd0, 5'd0, 5'd0, 6'h08};
		K_JALR:      return {6'h00, rs, 5'd0, rd, 5'd0, 6'h09};
		K_BAD_OPC:   return {6'h11, rs, rt, imm16}; // COP1 is not decoded
		K_BAD_FUNCT: return {6'h00, rs, rt, rd, 5'd0, 6'h01};
		default:     return {6'h27, rs, rt, imm16};
	endcase
endfunction

// expected record from the encoding rules
function automatic exp_t expect_record(int kind, uint32_t pc, uint32_t instr);
	exp_t    e;
	uint32_t pc4;
	uint32_t s16;
	pc4          = pc + 32'd4;
	s16          = {{16{instr[15]}}, instr[15:0]};
	e.pc         = pc;
	e.rs1        = '0;
	e.rs2        = '0;
	e.rd         = '0;
	e.op         = OP_INVALID;
	e.fu         = FU_INVALID;
	e.cf         = ControlFlow_None;
	e.use_imm    = 1'b0;
	e.imm_signed = 1'b1;
	e.imm        = s16;
	e.target     = '0;
	if (kind <= K_CLZ || kind == K_JR || kind == K_JALR || kind == K_BAD_FUNCT) begin
		e.rs1 = instr[25:21];
		e.rs2 = instr[20:16];
		e.rd  = instr[15:11];
	end else if (kind inside {K_ADDIU, K_ANDI, K_LUI, K_LW, K_LL, K_OPC_47}) begin
		e.rs1 = instr[25:21];
		e.rd  = instr[20:16];
	end else if (kind == K_SB || kind == K_BEQ) begin
		e.rs1 = instr[25:21];
		e.rs2 = instr[20:16];
	end
	case (kind)
		K_ADDU: begin
			e.op = OP_ADDU;
			e.fu = FU_ALU;
		end
		K_SLT: begin
			e.op = OP_SLT;
			e.fu = FU_ALU;
		end
		K_SLLV: begin
			e.op = OP_SLLV;
			e.fu = FU_ALU;
		end
		K_MULT: begin
			e.op = OP_MULT;
			e.fu = FU_MUL;
		end
		K_MADD: begin
			e.op = OP_MADD;
			e.fu = FU_MUL;
		end
		K_CLZ: begin
			e.op = OP_CLZ;
			e.fu = FU_MUL;
		end
		K_ADDIU: begin
			e.op      = OP_ADDU;
			e.fu      = FU_ALU;
			e.use_imm = 1'b1;
		end
		K_ANDI: begin
			e.op         = OP_AND;
			e.fu         = FU_ALU;
			e.use_imm    = 1'b1;
			e.imm_signed = 1'b0;
			e.imm        = {16'h0, instr[15:0]};
		end
		K_LUI: begin
			e.op         = OP_LUI;
			e.fu         = FU_ALU;
			e.use_imm    = 1'b1;
			e.imm_signed = 1'b0;
			e.imm        = {instr[15:0], 16'h0};
		end
		K_LW: begin
			e.op = OP_LW;
			e.fu = FU_LSU;
		end
		K_SB: begin
			e.op = OP_SB;
			e.fu = FU_LSU;
		end
		K_LL: begin
			e.op = OP_LL;
			e.fu = FU_LSU;
		end
		K_BEQ: begin
			e.op     = OP_BEQ;
			e.fu     = FU_BRANCH;
			e.cf     = ControlFlow_Branch;
			e.target = pc4 + (s16 << 2);
		end
		K_BGEZAL: begin
			e.rs1     = instr[25:21];
			e.rd      = REG_RA;
			e.use_imm = 1'b1;
			e.op      = OP_BGEZAL;
			e.fu      = FU_BRANCH;
			e.cf      = ControlFlow_Branch; // branch wins over call
			e.target  = pc4 + (s16 << 2);
		end
		K_J, K_JAL: begin
			e.rd     = (kind == K_JAL) ? REG_RA : 5'd0;
			e.op     = OP_JAL;
			e.fu     = FU_BRANCH;
			e.cf     = (kind == K_JAL) ? ControlFlow_Call : ControlFlow_Jump;
			e.target = {pc4[31:28], instr[25:0], 2'b00};
		end
		K_JR: begin
			e.op = OP_JALR;
			e.fu = FU_BRANCH;
			e.cf = ControlFlow_Return;
		end
		K_JALR: begin
			e.op = OP_JALR;
			e.fu = FU_BRANCH;
			e.cf = ControlFlow_Call;
		end
		default:  e.op = OP_INVALID;
	endcase
	return e;
endfunction

// call at a rising edge; returns at the edge that accepts
task automatic send_instr(int kind, uint32_t pc, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [15:0] imm16, logic [25:0] idx);
	uint32_t instr;
	instr = encode(kind, rs, rt, rd, imm16, idx);
	exp_q.push_back(expect_record(kind, pc, instr));
	in_valid <= 1'b1;
	in_pc    <= pc;
	in_instr <= instr;
	do
		@(negedge clk);
	while (!in_ready);
	@(posedge clk);
endtask

task automatic go_idle();
	in_valid <= 1'b0;
endtask

task automatic wait_drained();
	do
		@(posedge clk);
	while (exp_q.size() != 0);
endtask

task automatic reset_and_latency();
	cur_test = "reset";
	@(negedge clk);
	compare_bit("out_valid", 1'b0, out_valid);
	compare_bit("in_ready", 1'b1, in_ready);
	@(posedge clk);
	send_instr(K_ADDU, 32'h0040_0000, 5'd1, 5'd2, 5'd3, 16'h0, 26'h0);
	go_idle();
	@(negedge clk);
	compare_bit("out_valid", 1'b0, out_valid); // record still in buffer
	@(negedge clk);
	compare_bit("out_valid", 1'b1, out_valid); // leaves at the next edge
	wait_drained();
endtask

task automatic register_forms();
	cur_test = "reg_forms";
	send_instr(K_ADDU, 32'h0040_0010, 5'd4, 5'd5, 5'd6, 16'h0, 26'h0);
	send_instr(K_SLT, 32'h0040_0014, 5'd7, 5'd8, 5'd9, 16'h0, 26'h0);
	send_instr(K_SLLV, 32'h0040_0018, 5'd10, 5'd11, 5'd12, 16'h0, 26'h0);
	send_instr(K_MULT, 32'h0040_001c, 5'd13, 5'd14, 5'd0, 16'h0, 26'h0);
	send_instr(K_MADD, 32'h0040_0020, 5'd15, 5'd16, 5'd0, 16'h0, 26'h0);
	send_instr(K_CLZ, 32'h0040_0024, 5'd17, 5'd0, 5'd18, 16'h0, 26'h0);
	go_idle();
	wait_drained();
endtask

task automatic immediate_forms();
	cur_test = "imm_forms";
	send_instr(K_ADDIU, 32'h0040_0030, 5'd1, 5'd2, 5'd0, 16'hfff4, 26'h0);
	send_instr(K_ANDI, 32'h0040_0034, 5'd3, 5'd4, 5'd0, 16'h8001, 26'h0);
	send_instr(K_LUI, 32'h0040_0038, 5'd0, 5'd5, 5'd0, 16'hbeef, 26'h0);
	send_instr(K_LW, 32'h0040_003c, 5'd29, 5'd6, 5'd0, 16'hfffc, 26'h0);
	send_instr(K_SB, 32'h0040_0040, 5'd29, 5'd7, 5'd0, 16'h0010, 26'h0);
	send_instr(K_LL, 32'h0040_0044, 5'd8, 5'd9, 5'd0, 16'h0004, 26'h0);
	go_idle();
	wait_drained();
endtask

task automatic control_flow();
	cur_test = "control_flow";
	send_instr(K_BEQ, 32'h0040_0100, 5'd1, 5'd2, 5'd0, 16'h0010, 26'h0);
	send_instr(K_BEQ, 32'h0040_2000, 5'd3, 5'd3, 5'd0, 16'hfff0, 26'h0); // backward
	send_instr(K_BGEZAL, 32'h0040_0104, 5'd4, 5'd0, 5'd0, 16'h0020, 26'h0);
	send_instr(K_J, 32'h1fff_fffc, 5'd0, 5'd0, 5'd0, 16'h0, 26'h0123456);
	send_instr(K_JAL, 32'h0040_0200, 5'd0, 5'd0, 5'd0, 16'h0, 26'h3ff_ffff);
	send_instr(K_JR, 32'h0040_0204, 5'd31, 5'd0, 5'd0, 16'h0, 26'h0);
	send_instr(K_JALR, 32'h0040_0208, 5'd4, 5'd0, 5'd31, 16'h0, 26'h0);
	go_idle();
	wait_drained();
endtask

task automatic invalid_encodings();
	cur_test = "invalid";
	send_instr(K_BAD_OPC, 32'h0040_0300, 5'd1, 5'd2, 5'd0, 16'h1234, 26'h0);
	send_instr(K_BAD_FUNCT, 32'h0040_0304, 5'd3, 5'd4, 5'd5, 16'h0, 26'h0);
	send_instr(K_OPC_47, 32'h0040_0308, 5'd6, 5'd7, 5'd0, 16'h8000, 26'h0);
	go_idle();
	wait_drained();
endtask

task automatic back_pressure();
	int kind;
	cur_test     = "back_pressure";
	random_ready <= 1'b1;
	for (int i = 0; i < 40; i++) begin
		kind = $urandom_range(K_ADDU, K_JALR);
		send_instr(kind, 32'h0080_0000 + 32'(i * 4), reg_addr_t'($urandom_range(0, 31)),
			reg_addr_t'($urandom_range(0, 31)), reg_addr_t'($urandom_range(0, 31)),
			16'($urandom), 26'($urandom));
	end
	go_idle();
	random_ready <= 1'b0;
	wait_drained();
endtask

always @(posedge clk) begin
	if (random_ready)
		out_ready <= 1'($urandom_range(0, 1));
	else
		out_ready <= 1'b1;
end

// pops records as they leave and checks them
always @(negedge clk) begin
	exp_t e;
	if (rst_n && out_valid && out_ready) begin
		if (exp_q.size() == 0) begin
			$display("unexpected record left the stage at pc %h", out_pc);
			other_errors++;
		end else begin
			e = exp_q.pop_front();
			compare_word("pc", e.pc, out_pc);
			compare_reg("rs1", e.rs1, out_rs1);
			compare_reg("rs2", e.rs2, out_rs2);
			compare_reg("rd", e.rd, out_rd);
			compare_op(e.op, out_op);
			compare_fu(e.fu, out_fu);
			compare_cf(e.cf, out_cf);
			compare_bit("use_imm", e.use_imm, out_use_imm);
			compare_bit("imm_signed", e.imm_signed, out_imm_signed);
			compare_word("imm", e.imm, out_imm);
			compare_word("target", e.target, out_target);
		end
	end
end

// in_ready may only fall when the stage is full
always @(negedge clk) begin
	if (!rst_n) begin
		held     = 0;
		pend_in  = 1'b0;
		pend_out = 1'b0;
	end else begin
		held = held + int'(pend_in) - int'(pend_out);
		if (!in_ready && held != QUEUE_DEPTH + 2) begin
			$display("in_ready low while the stage held %0d records", held);
			other_errors++;
		end
		pend_in  = in_valid && in_ready;
		pend_out = out_valid && out_ready;
	end
end

initial begin
	#((20 * N_INSTR + 200) * 100);
	$display("timeout: the stage stopped delivering records");
	$display("Finished with errors");
	$finish;
end

initial begin
	void'($urandom(99511));
	clk          = 1'b0;
	rst_n        = 1'b0;
	in_valid     = 1'b0;
	in_pc        = '0;
	in_instr     = '0;
	out_ready    = 1'b1;
	random_ready = 1'b0;
	value_errors = 0;
	other_errors = 0;
	cur_test     = "none";
	repeat (5) @(posedge clk);
	rst_n <= 1'b1;
	reset_and_latency();
	register_forms();
	immediate_forms();
	control_flow();
	invalid_encodings();
	back_pressure();
	repeat (4) @(posedge clk);
	$display("value errors: %0d, other errors: %0d, assertion failures: %0d",
		value_errors, other_errors, dut_i.checker_i.fail_count);
	if (value_errors == 0 && other_errors == 0 && dut_i.checker_i.fail_count == 0)
		$display("Finished with no errors");
	else
		$display("Finished with errors");
	$finish;
end

endmodule

`default_nettype wire

//--- testbench/decode_stage_checker.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_checker (
	input logic               clk,
	input logic               rst_n,
	input logic               in_ready,
	input logic               out_valid,
	input logic               out_ready,
	input cpu_pkg::uint32_t   out_pc,
	input cpu_pkg::reg_addr_t out_rs1,
	input cpu_pkg::reg_addr_t out_rs2,
	input cpu_pkg::reg_addr_t out_rd,
	input decode_pkg::op_t    out_op,
	input decode_pkg::fu_t    out_fu,
	input decode_pkg::cf_t    out_cf,
	input logic               out_use_imm,
	input logic               out_imm_signed,
	input cpu_pkg::uint32_t   out_imm,
	input cpu_pkg::uint32_t   out_target
);

import decode_pkg::*;

int fail_count = 0; // failed assertions so far

stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
	(out_valid && !out_ready) |=> (out_valid && $stable(out_pc) && $stable(out_rs1)
		&& $stable(out_rs2) && $stable(out_rd) && $stable(out_op) && $stable(out_fu)
		&& $stable(out_cf) && $stable(out_use_imm) && $stable(out_imm_signed)
		&& $stable(out_imm) && $stable(out_target)))
	else begin
		fail_count++;
		$error("output record changed while out_ready was low");
	end

ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
	else begin
		fail_count++;
		$error("in_ready low in the first cycle after reset");
	end

valid_op_unit: assert property (@(posedge clk) disable iff (!rst_n)
	(out_valid && out_fu != FU_INVALID) |-> out_op != OP_INVALID)
	else begin
		fail_count++;
		$error("invalid op reported with a real functional unit");
	end

endmodule

bind decode_stage decode_stage_checker checker_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.in_ready       (in_ready),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.out_pc         (out_pc),
	.out_rs1        (out_rs1),
	.out_rs2        (out_rs2),
	.out_rd         (out_rd),
	.out_op         (out_op),
	.out_fu         (out_fu),
	.out_cf         (out_cf),
	.out_use_imm    (out_use_imm),
	.out_imm_signed (out_imm_signed),
	.out_imm        (out_imm),
	.out_target     (out_target)
);

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage #(
	parameter int               QUEUE_DEPTH = 4,
	parameter cpu_pkg::uint32_t RESET_PC    = '0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::uint32_t   in_pc,
	input  cpu_pkg::uint32_t   in_instr,
	output logic               out_valid,
	input  logic               out_ready,
	output cpu_pkg::uint32_t   out_pc,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output decode_pkg::op_t    out_op,
	output decode_pkg::fu_t    out_fu,
	output decode_pkg::cf_t    out_cf,
	output logic               out_use_imm,
	output logic               out_imm_signed,
	output cpu_pkg::uint32_t   out_imm,
	output cpu_pkg::uint32_t   out_target
);

import cpu_pkg::*;
import decode_pkg::*;

logic      buf_valid;
logic      buf_ready;
uint32_t   buf_pc;
uint32_t   buf_instr;
reg_addr_t dec_rs1;
reg_addr_t dec_rs2;
reg_addr_t dec_rd;
op_t       dec_op;
fu_t       dec_fu;
cf_t       dec_cf;
logic      dec_use_imm;
logic      dec_imm_signed;
uint32_t   dec_imm;
uint32_t   dec_target;

fetch_buffer #(
	.RESET_PC (RESET_PC)
) fetch_buffer_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.in_pc     (in_pc),
	.in_instr  (in_instr),
	.buf_valid (buf_valid),
	.buf_ready (buf_ready),
	.buf_pc    (buf_pc),
	.buf_instr (buf_instr)
);

decoder decoder_i (
	.instr      (buf_instr),
	.pc         (buf_pc),
	.rs1        (dec_rs1),
	.rs2        (dec_rs2),
	.rd         (dec_rd),
	.op         (dec_op),
	.fu         (dec_fu),
	.cf         (dec_cf),
	.use_imm    (dec_use_imm),
	.imm_signed (dec_imm_signed),
	.imm        (dec_imm),
	.target     (dec_target)
);

decode_queue #(
	.QUEUE_DEPTH (QUEUE_DEPTH)
) decode_queue_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.in_valid       (buf_valid),
	.in_ready       (buf_ready),
	.in_pc          (buf_pc),
	.in_rs1         (dec_rs1),
	.in_rs2         (dec_rs2),
	.in_rd          (dec_rd),
	.in_op          (dec_op),
	.in_fu          (dec_fu),
	.in_cf          (dec_cf),
	.in_use_imm     (dec_use_imm),
	.in_imm_signed  (dec_imm_signed),
	.in_imm         (dec_imm),
	.in_target      (dec_target),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.out_pc         (out_pc),
	.out_rs1        (out_rs1),
	.out_rs2        (out_rs2),
	.out_rd         (out_rd),
	.out_op         (out_op),
	.out_fu         (out_fu),
	.out_cf         (out_cf),
	.out_use_imm    (out_use_imm),
	.out_imm_signed (out_imm_signed),
	.out_imm        (out_imm),
	.out_target     (out_target)
);

endmodule

`default_nettype wire

//--- rtl/decode_queue.sv
`timescale 1ns/10ps
`default_nettype none

module decode_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::uint32_t   in_pc,
	input  cpu_pkg::reg_addr_t in_rs1,
	input  cpu_pkg::reg_addr_t in_rs2,
	input  cpu_pkg::reg_addr_t in_rd,
	input  decode_pkg::op_t    in_op,
	input  decode_pkg::fu_t    in_fu,
	input  decode_pkg::cf_t    in_cf,
	input  logic               in_use_imm,
	input  logic               in_imm_signed,
	input  cpu_pkg::uint32_t   in_imm,
	input  cpu_pkg::uint32_t   in_target,
	output logic               out_valid,
	input  logic               out_ready,
	output cpu_pkg::uint32_t   out_pc,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output decode_pkg::op_t    out_op,
	output decode_pkg::fu_t    out_fu,
	output decode_pkg::cf_t    out_cf,
	output logic               out_use_imm,
	output logic               out_imm_signed,
	output cpu_pkg::uint32_t   out_imm,
	output cpu_pkg::uint32_t   out_target
);

import cpu_pkg::*;
import decode_pkg::*;

localparam int PTR_W = $clog2(QUEUE_DEPTH);

typedef struct packed {
	uint32_t   pc;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	op_t       op;
	fu_t       fu;
	cf_t       cf;
	logic      use_imm;
	logic      imm_signed;
	uint32_t   imm;
	uint32_t   target;
} rec_t;

rec_t             mem [QUEUE_DEPTH];
rec_t             head;
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   count;
logic             wr_en;
logic             rd_en;

assign out_valid = count != '0;
assign in_ready  = (count != (PTR_W + 1)'(QUEUE_DEPTH)) | out_ready; // pass-through when full
assign wr_en     = in_valid & in_ready;
assign rd_en     = out_valid & out_ready;

always_ff @(posedge clk) begin
	if (wr_en)
		mem[wr_ptr] <= '{in_pc, in_rs1, in_rs2, in_rd, in_op, in_fu, in_cf,
			in_use_imm, in_imm_signed, in_imm, in_target};
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (wr_en)
			wr_ptr <= wr_ptr + PTR_W'(1); // wraps, depth is 2^n
		if (rd_en)
			rd_ptr <= rd_ptr + PTR_W'(1);
		case ({wr_en, rd_en})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

assign head           = mem[rd_ptr];
assign out_pc         = head.pc;
assign out_rs1        = head.rs1;
assign out_rs2        = head.rs2;
assign out_rd         = head.rd;
assign out_op         = head.op;
assign out_fu         = head.fu;
assign out_cf         = head.cf;
assign out_use_imm    = head.use_imm;
assign out_imm_signed = head.imm_signed;
assign out_imm        = head.imm;
assign out_target     = head.target;

endmodule

`default_nettype wire

//--- rtl/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
	input  cpu_pkg::uint32_t   instr,
	input  cpu_pkg::uint32_t   pc,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output cpu_pkg::reg_addr_t rd,
	output decode_pkg::op_t    op,
	output decode_pkg::fu_t    fu,
	output decode_pkg::cf_t    cf,
	output logic               use_imm,
	output logic               imm_signed,
	output cpu_pkg::uint32_t   imm,
	output cpu_pkg::uint32_t   target
);

import cpu_pkg::*;
import decode_pkg::*;

logic [5:0] opcode;
logic [5:0] funct;
reg_addr_t  fld_rs;
reg_addr_t  fld_rt;
reg_addr_t  fld_rd;
logic       is_branch;
logic       is_jump_i;
logic       is_jump_r;
logic       is_call;
logic       is_return;
logic       grp_mul;
logic       grp_mem;
logic       grp_cop0;

assign opcode = instr[OPCODE_LSB +: 6];
assign funct  = instr[FUNCT_LSB +: 6];
assign fld_rs = instr[RS_LSB +: 5];
assign fld_rt = instr[RT_LSB +: 5];
assign fld_rd = instr[RD_LSB +: 5];

decode_branch branch_i (
	.instr     (instr),
	.pc        (pc),
	.is_branch (is_branch),
	.is_jump_i (is_jump_i),
	.is_jump_r (is_jump_r),
	.is_call   (is_call),
	.is_return (is_return),
	.target    (target)
);

always_comb begin
	unique casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
		4'b1???: cf = ControlFlow_Branch;
		4'b01??: cf = ControlFlow_Return;
		4'b001?: cf = ControlFlow_Call;
		4'b0001: cf = ControlFlow_Jump;
		default: cf = ControlFlow_None;
	endcase
end

always_comb begin
	rs1        = '0;
	rs2        = '0;
	rd         = '0;
	op         = OP_INVALID;
	use_imm    = 1'b0;
	imm_signed = 1'b1;
	grp_mul    = 1'b0;
	grp_mem    = 1'b0;
	grp_cop0   = 1'b0;

	unique casez (opcode)
		OPC_SPECIAL: begin
			rs1     = fld_rs;
			rs2     = fld_rt;
			rd      = fld_rd;
			grp_mul = funct[5:2] == 4'b0110; // mult, div
			unique case (funct)
				6'b000000: op = OP_SLL;
				6'b000010: op = OP_SRL;
				6'b000011: op = OP_SRA;
				6'b000100: op = OP_SLLV;
				6'b000110: op = OP_SRLV;
				6'b000111: op = OP_SRAV;
				6'b001000: op = OP_JALR; // JR too
				6'b001001: op = OP_JALR;
				6'b001011: op = OP_MOVN;
				6'b001010: op = OP_MOVZ;
				6'b001100: op = OP_SYSCALL;
				6'b001101: op = OP_BREAK;
				6'b001111: op = OP_SLL; // sync as nop
				6'b010000: op = OP_MFHI;
				6'b010001: op = OP_MTHI;
				6'b010010: op = OP_MFLO;
				6'b010011: op = OP_MTLO;
				6'b011000: op = OP_MULT;
				6'b011001: op = OP_MULTU;
				6'b011010: op = OP_DIV;
				6'b011011: op = OP_DIVU;
				6'b100000: op = OP_ADD;
				6'b100001: op = OP_ADDU;
				6'b100010: op = OP_SUB;
				6'b100011: op = OP_SUBU;
				6'b100100: op = OP_AND;
				6'b100101: op = OP_OR;
				6'b100110: op = OP_XOR;
				6'b100111: op = OP_NOR;
				6'b101010: op = OP_SLT;
				6'b101011: op = OP_SLTU;
				6'b110000: op = OP_TGE;
				6'b110001: op = OP_TGEU;
				6'b110010: op = OP_TLT;
				6'b110011: op = OP_TLTU;
				6'b110100: op = OP_TEQ;
				6'b110110: op = OP_TNE;
				default:   op = OP_INVALID;
			endcase
		end
		OPC_SPECIAL2: begin
			rs1     = fld_rs;
			rs2     = fld_rt;
			rd      = fld_rd;
			grp_mul = 1'b1;
			unique case (funct)
				6'b000000: op = OP_MADD;
				6'b000001: op = OP_MADDU;
				6'b000100: op = OP_MSUB;
				6'b000101: op = OP_MSUBU;
				6'b000010: op = OP_MUL;
				6'b100000: op = OP_CLZ;
				6'b100001: op = OP_CLO;
				default:   op = OP_INVALID;
			endcase
		end
		OPC_REGIMM: begin
			rs1     = fld_rs;
			rd      = (fld_rt[4:1] == 4'b1000) ? REG_RA : '0; // linking branches
			use_imm = 1'b1;
			unique case (fld_rt)
				5'b01000: op = OP_TGE;
				5'b01001: op = OP_TGEU;
				5'b01010: op = OP_TLT;
				5'b01011: op = OP_TLTU;
				5'b01100: op = OP_TEQ;
				5'b01110: op = OP_TNE;
				5'b00000: op = OP_BLTZ;
				5'b00001: op = OP_BGEZ;
				5'b10000: op = OP_BLTZAL;
				5'b10001: op = OP_BGEZAL;
				default:  op = OP_INVALID;
			endcase
		end
		6'b0001??: begin
			rs1 = fld_rs;
			rs2 = fld_rt;
			unique case (opcode[1:0])
				2'b00: op = OP_BEQ;
				2'b01: op = OP_BNE;
				2'b10: op = OP_BLEZ;
				2'b11: op = OP_BGTZ;
			endcase
		end
		6'b001???: begin
			rs1        = fld_rs;
			rd         = fld_rt;
			use_imm    = 1'b1;
			imm_signed = ~opcode[2]; // logical ops zero-extend
			unique case (opcode[2:0])
				3'b100: op = OP_AND;
				3'b101: op = OP_OR;
				3'b110: op = OP_XOR;
				3'b111: op = OP_LUI;
				3'b000: op = OP_ADD;
				3'b001: op = OP_ADDU;
				3'b010: op = OP_SLT;
				3'b011: op = OP_SLTU;
			endcase
		end
		6'b100???: begin
			rs1     = fld_rs;
			rs2     = (opcode[1:0] == 2'b10) ? fld_rt : '0; // LWL/LWR merge into rt
			rd      = fld_rt;
			grp_mem = 1'b1;
			unique case (opcode[2:0])
				3'b000: op = OP_LB;
				3'b001: op = OP_LH;
				3'b010: op = OP_LWL;
				3'b011: op = OP_LW;
				3'b100: op = OP_LBU;
				3'b101: op = OP_LHU;
				3'b110: op = OP_LWR;
				3'b111: op = OP_INVALID;
			endcase
		end
		6'b101???: begin
			rs1     = fld_rs;
			rs2     = fld_rt;
			grp_mem = 1'b1;
			unique case (opcode[2:0])
				3'b000:  op = OP_SB;
				3'b001:  op = OP_SH;
				3'b010:  op = OP_SWL;
				3'b011:  op = OP_SW;
				3'b110:  op = OP_SWR;
				3'b111:  op = OP_CACHE;
				default: op = OP_INVALID;
			endcase
		end
		OPC_LL: begin
			rs1     = fld_rs;
			rd      = fld_rt;
			op      = OP_LL;
			grp_mem = 1'b1;
		end
		OPC_SC: begin
			rs1     = fld_rs;
			rs2     = fld_rt;
			rd      = fld_rt; // success flag
			op      = OP_SC;
			grp_mem = 1'b1;
		end
		6'b00001?: begin
			rd = {$bits(reg_addr_t){opcode[0]}}; // r31 for JAL only
			op = OP_JAL;
		end
		OPC_COP0: begin
			grp_cop0 = 1'b1;
			unique case (fld_rs)
				5'b00000: begin
					op = OP_MFC0;
					rd = fld_rt;
				end
				5'b00100: begin
					op  = OP_MTC0;
					rs1 = fld_rt;
				end
				5'b10000: begin
					unique case (funct)
						6'b000001: op = OP_TLBR;
						6'b000010: op = OP_TLBWI;
						6'b000110: op = OP_TLBWR;
						6'b001000: op = OP_TLBP;
						6'b011000: op = OP_ERET;
						default:   op = OP_INVALID;
					endcase
				end
				default: op = OP_INVALID;
			endcase
		end
		default: op = OP_INVALID;
	endcase
end

always_comb begin
	if (op == OP_INVALID)
		fu = FU_INVALID;
	else if (grp_mul)
		fu = FU_MUL;
	else if (grp_mem)
		fu = FU_LSU;
	else if (is_branch | is_jump_i | is_jump_r)
		fu = FU_BRANCH;
	else if (grp_cop0)
		fu = FU_COP0;
	else
		fu = FU_ALU;
end

always_comb begin
	if (opcode == OPC_LUI)
		imm = {instr[IMM16_W-1:0], {IMM16_W{1'b0}}};
	else if (imm_signed)
		imm = {{(32 - IMM16_W){instr[IMM16_W-1]}}, instr[IMM16_W-1:0]};
	else
		imm = {{(32 - IMM16_W){1'b0}}, instr[IMM16_W-1:0]};
end

endmodule

`default_nettype wire

//--- rtl/decode_branch.sv
`timescale 1ns/10ps
`default_nettype none

module decode_branch (
	input  cpu_pkg::uint32_t instr,
	input  cpu_pkg::uint32_t pc,
	output logic             is_branch,
	output logic             is_jump_i,
	output logic             is_jump_r,
	output logic             is_call,
	output logic             is_return,
	output cpu_pkg::uint32_t target
);

import cpu_pkg::*;

logic [5:0] opcode;
logic [5:0] funct;
reg_addr_t  rs;
reg_addr_t  rt;
logic       regimm_br;
uint32_t    pc_next;
uint32_t    br_offset;

assign opcode = instr[OPCODE_LSB +: 6];
assign funct  = instr[FUNCT_LSB +: 6];
assign rs     = instr[RS_LSB +: 5];
assign rt     = instr[RT_LSB +: 5];

// BLTZ, BGEZ, BLTZAL, BGEZAL
assign regimm_br = (opcode == OPC_REGIMM) && (rt[3:1] == 3'b000);

assign is_branch = regimm_br || (opcode inside {OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ});
assign is_jump_i = opcode inside {OPC_J, OPC_JAL};
assign is_jump_r = (opcode == OPC_SPECIAL) && (funct[5:1] == 5'b00100); // JR, JALR

assign is_call   = (opcode == OPC_JAL) | (is_jump_r & funct[0]) | (regimm_br & rt[4]);
assign is_return = is_jump_r & ~funct[0] & (rs == REG_RA);

assign pc_next   = pc + 32'd4;
assign br_offset = {{(30 - IMM16_W){instr[IMM16_W-1]}}, instr[IMM16_W-1:0], 2'b00};

always_comb begin
	if (is_branch)
		target = pc_next + br_offset;
	else if (is_jump_i)
		target = {pc_next[31:INDEX_W+2], instr[INDEX_W-1:0], 2'b00}; // stays in 256MB region
	else
		target = '0;
end

endmodule

`default_nettype wire

//--- rtl/fetch_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer #(
	parameter cpu_pkg::uint32_t RESET_PC = '0
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  cpu_pkg::uint32_t in_pc,
	input  cpu_pkg::uint32_t in_instr,
	output logic             buf_valid,
	input  logic             buf_ready,
	output cpu_pkg::uint32_t buf_pc,
	output cpu_pkg::uint32_t buf_instr
);

import cpu_pkg::*;

logic    main_valid;
logic    spare_valid;
uint32_t main_pc;
uint32_t main_instr;
uint32_t spare_pc;
uint32_t spare_instr;
logic    in_fire;
logic    main_free;

assign in_ready  = ~spare_valid; // straight from a flop
assign in_fire   = in_valid & in_ready;
assign main_free = ~main_valid | buf_ready; // main drains this cycle

assign buf_valid = main_valid;
assign buf_pc    = main_valid ? main_pc : RESET_PC;
assign buf_instr = main_valid ? main_instr : '0;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		main_valid  <= 1'b0;
		spare_valid <= 1'b0;
	end else if (main_free) begin
		main_valid  <= spare_valid | in_fire;
		spare_valid <= 1'b0;
	end else if (in_fire) begin
		spare_valid <= 1'b1; // downstream stalled, park it
	end
end

always_ff @(posedge clk) begin
	if (main_free) begin
		if (spare_valid) begin
			main_pc    <= spare_pc;
			main_instr <= spare_instr;
		end else if (in_fire) begin
			main_pc    <= in_pc;
			main_instr <= in_instr;
		end
	end else if (in_fire) begin
		spare_pc    <= in_pc;
		spare_instr <= in_instr;
	end
end

endmodule

`default_nettype wire

//--- rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

typedef enum logic [6:0] {
	// SPECIAL
	OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
	OP_JALR, OP_MOVN, OP_MOVZ, OP_SYSCALL, OP_BREAK,
	OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
	OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
	OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
	OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
	OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_TEQ, OP_TNE,
	// SPECIAL2
	OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_MUL, OP_CLZ, OP_CLO,
	// branches
	OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
	OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
	OP_LUI,
	// memory
	OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
	OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR, OP_CACHE,
	OP_LL, OP_SC,
	OP_JAL,
	// COP0 and TLB
	OP_MFC0, OP_MTC0,
	OP_TLBR, OP_TLBWI, OP_TLBWR, OP_TLBP, OP_ERET,
	OP_INVALID
} op_t;

typedef enum logic [2:0] {
	FU_ALU,
	FU_MUL,
	FU_LSU,
	FU_BRANCH,
	FU_COP0,
	FU_INVALID
} fu_t;

typedef enum logic [2:0] {
	ControlFlow_None,
	ControlFlow_Branch,
	ControlFlow_Jump,
	ControlFlow_Call,
	ControlFlow_Return
} cf_t;

endpackage

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;

localparam reg_addr_t REG_RA = 5'd31; // link register

// field positions in the instruction word
localparam int OPCODE_LSB = 26;
localparam int RS_LSB     = 21;
localparam int RT_LSB     = 16;
localparam int RD_LSB     = 11;
localparam int FUNCT_LSB  = 0;
localparam int IMM16_W    = 16;
localparam int INDEX_W    = 26;

typedef enum logic [5:0] {
	OPC_SPECIAL  = 6'b000000,
	OPC_REGIMM   = 6'b000001,
	OPC_J        = 6'b000010,
	OPC_JAL      = 6'b000011,
	OPC_BEQ      = 6'b000100,
	OPC_BNE      = 6'b000101,
	OPC_BLEZ     = 6'b000110,
	OPC_BGTZ     = 6'b000111,
	OPC_LUI      = 6'b001111,
	OPC_COP0     = 6'b010000,
	OPC_SPECIAL2 = 6'b011100,
	OPC_LL       = 6'b110000,
	OPC_SC       = 6'b111000
} opcode_e;

endpackage

`default_nettype wire
